// File: hdl/asyncFifoBram.sv
/*
 * dual-clock block-RAM FIFO, 1 to 360 bits wide, 512 deep
 * first-word-fall-through read, full raised early by Offset so the
 * two-stage write pipeline never overruns
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module asyncFifoBram #(
    parameter int Width  = 128,             // 1 to 360
    parameter int Offset = `DEF_OFFSET      // almost full / empty threshold
) (
    input  logic             wr_clk,
    input  logic             wr_rst_q,
    input  logic             rdClk,
    input  logic             rdRst,
    input  logic [Width-1:0] din,
    input  logic             wrEn,
    output logic             full,
    output logic [Width-1:0] dout,
    input  logic             rdEn,
    output logic             empty
);

    // one lane per started 72 bit slice
    localparam int NumLanes = (Width + `LANE_WIDTH - 1) / `LANE_WIDTH;

    bramFifoPkg::laneWord_t [`MAX_LANES-1:0] laneDin;
    bramFifoPkg::laneWord_t [NumLanes-1:0]   laneDout;
    logic [NumLanes*`LANE_WIDTH-1:0]         laneFlat;   // lanes side by side
    logic                                    memWrite;
    logic                                    almostFull;
    bramFifoPkg::ptr_t                       wrPtr;
    bramFifoPkg::ptr_t                       rdPtr;
    bramFifoPkg::ptr_t                       wrPtrSync;  // in read domain
    bramFifoPkg::ptr_t                       rdPtrSync;  // in write domain

    if (Width < 1 || Width > `MAX_LANES * `LANE_WIDTH) begin : gBadWidth
        $error("asyncFifoBram: Width %0d outside 1 to 360", Width);
    end

    ////////////////////////////////////////////////////////////////////////////
    // write domain
    ////////////////////////////////////////////////////////////////////////////

    writeStage #(.Width(Width)) uWriteStage (
        .wr_clk     (wr_clk),
        .wr_rst_q   (wr_rst_q),
        .din        (din),
        .wrEn       (wrEn),
        .almostFull (almostFull),
        .full       (full),
        .laneDin    (laneDin),
        .memWrite   (memWrite)
    );

    wrPtrCtrl #(.Offset(Offset)) uWrPtrCtrl (
        .wr_clk     (wr_clk),
        .wr_rst_q   (wr_rst_q),
        .memWrite   (memWrite),
        .rdPtrSync  (rdPtrSync),
        .wrPtr      (wrPtr),
        .almostFull (almostFull)
    );

    ////////////////////////////////////////////////////////////////////////////
    // crossings and read domain
    ////////////////////////////////////////////////////////////////////////////

    grayPtrSync uWrSync (                   // write pointer into read domain
        .srcClk (wr_clk),
        .srcRst (wr_rst_q),
        .dstClk (rdClk),
        .dstRst (rdRst),
        .ptrIn  (wrPtr),
        .ptrOut (wrPtrSync)
    );

    grayPtrSync uRdSync (                   // read pointer back to the writer
        .srcClk (rdClk),
        .srcRst (rdRst),
        .dstClk (wr_clk),
        .dstRst (wr_rst_q),
        .ptrIn  (rdPtr),
        .ptrOut (rdPtrSync)
    );

    rdPtrCtrl #(.Offset(Offset)) uRdPtrCtrl (
        .rdClk     (rdClk),
        .rdRst     (rdRst),
        .rdEn      (rdEn),
        .wrPtrSync (wrPtrSync),
        .rdPtr     (rdPtr),
        .empty     (empty)
    );

    // lanes share both pointers, so one flag set covers them all
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        fifoLane uLane (
            .wr_clk   (wr_clk),
            .rdClk    (rdClk),
            .memWrite (memWrite),
            .wrAddr   (wrPtr[`ADDR_BITS-1:0]),
            .laneDin  (laneDin[i]),
            .rdAddr   (rdPtr[`ADDR_BITS-1:0]),
            .laneDout (laneDout[i])
        );
    end

    assign laneFlat = laneDout;
    assign dout     = laneFlat[Width-1:0];  // drop the padding of the top lane

endmodule

// File: hdl/bramFifoPkg.sv
/*
 * shared types for the dual-clock BRAM FIFO
 * lane word and read / write pointer
 */
`include "bramFifo_defines.svh"

package bramFifoPkg;

    ////////////////////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////////////////////

    // one lane worth of data, all lanes carry the same word type
    typedef logic [`LANE_WIDTH-1:0] laneWord_t;

    ////////////////////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////////////////////

    // address plus wrap bit at the top
    // binary inside each domain, gray only on the crossing
    typedef logic [`ADDR_BITS:0] ptr_t;

endpackage

// File: hdl/bramFifo_defines.svh
/*
 * dual-clock BRAM FIFO sizing constants
 * lane geometry, depth, pointer address bits and the default
 * almost-full / almost-empty threshold
 */
`ifndef BRAMFIFO_DEFINES_SVH
`define BRAMFIFO_DEFINES_SVH

// bits in one memory lane
`define LANE_WIDTH 72

// entries per lane
`define FIFO_DEPTH 512
`define ADDR_BITS  9      // log2 of depth without the wrap bit

// five lanes give the 360 bit ceiling
`define MAX_LANES  5

`define DEF_OFFSET 16     // free or used entries that raise the almost flags

`endif

// File: hdl/fifoLane.sv
/*
 * one 512 x 72 dual-clock memory lane
 * written on the write clock, read register on the read clock
 * loaded from the lookahead head address for fall-through output
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module fifoLane (
    input  logic                   wr_clk,
    input  logic                   rdClk,
    input  logic                   memWrite,
    input  logic [`ADDR_BITS-1:0]  wrAddr,
    input  bramFifoPkg::laneWord_t laneDin,
    input  logic [`ADDR_BITS-1:0]  rdAddr,     // next head
    output bramFifoPkg::laneWord_t laneDout
);

    bramFifoPkg::laneWord_t mem [0:`FIFO_DEPTH-1];

    // write port
    always_ff @(posedge wr_clk) begin
        if (memWrite) begin
            mem[wrAddr] <= laneDin;
        end
    end

    // read port, reloads every cycle
    // a word written while the head sat idle shows up well before
    // empty falls, the crossing takes longer than one read cycle
    always_ff @(posedge rdClk) begin
        laneDout <= mem[rdAddr];
    end

endmodule

// File: hdl/grayPtrSync.sv
/*
 * pointer crossing between the two clock domains
 * gray encode in the source domain, two destination flops,
 * then back to binary
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module grayPtrSync (
    input  logic              srcClk,
    input  logic              srcRst,
    input  logic              dstClk,
    input  logic              dstRst,
    input  bramFifoPkg::ptr_t ptrIn,      // binary, source domain
    output bramFifoPkg::ptr_t ptrOut      // binary, destination domain
);

    bramFifoPkg::ptr_t grayQ;             // launched from a flop, no glitches
    bramFifoPkg::ptr_t syncQ1;
    bramFifoPkg::ptr_t syncQ2;

    function automatic bramFifoPkg::ptr_t grayToBin(input bramFifoPkg::ptr_t g);
        bramFifoPkg::ptr_t b;
        b[`ADDR_BITS] = g[`ADDR_BITS];    // msb passes straight
        for (int i = `ADDR_BITS - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    always_ff @(posedge srcClk) begin
        if (srcRst) grayQ <= '0;
        else        grayQ <= ptrIn ^ (ptrIn >> 1);
    end

    // only one bit moves per step, so each flop sees a clean value
    always_ff @(posedge dstClk) begin
        if (dstRst) begin
            syncQ1 <= '0;
            syncQ2 <= '0;
        end else begin
            syncQ1 <= grayQ;
            syncQ2 <= syncQ1;
        end
    end

    assign ptrOut = grayToBin(syncQ2);

endmodule

// File: hdl/rdPtrCtrl.sv
/*
 * read pointer and empty flag
 * pops on rdEn while empty is low, forms raw and almost empty from
 * the synchronized write pointer and paces empty near the bottom
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module rdPtrCtrl #(
    parameter int Offset = `DEF_OFFSET      // used entries at or below this are almost empty
) (
    input  logic              rdClk,
    input  logic              rdRst,
    input  logic              rdEn,
    input  bramFifoPkg::ptr_t wrPtrSync,    // write pointer, already in this domain
    output bramFifoPkg::ptr_t rdPtr,        // lookahead, the head after this edge
    output logic              empty
);

    bramFifoPkg::ptr_t rdPtrQ;              // current head
    bramFifoPkg::ptr_t usedCnt;
    logic              wrapDiff;
    logic              pop;
    logic              rawEmpty;
    logic              almostEmpty;

    assign pop = rdEn & ~empty;             // rdEn on empty is dropped

    // lanes register their read, so they get the next head address
    assign rdPtr = rdPtrQ + {{`ADDR_BITS{1'b0}}, pop};

    ////////////////////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////////////////////

    assign wrapDiff    = wrPtrSync[`ADDR_BITS] ^ rdPtrQ[`ADDR_BITS];
    assign usedCnt     = {wrapDiff, wrPtrSync[`ADDR_BITS-1:0]}
                       - {1'b0, rdPtrQ[`ADDR_BITS-1:0]};
    assign rawEmpty    = (usedCnt == '0);
    assign almostEmpty = (int'(usedCnt) <= Offset);

    always_ff @(posedge rdClk) begin
        if (rdRst) rdPtrQ <= '0;
        else       rdPtrQ <= rdPtr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // empty flag
    ////////////////////////////////////////////////////////////////////////////

    // well above the bottom, never empty
    // near the bottom a pop forces one empty cycle so the lane read
    // register can catch up before the next word is offered
    always_ff @(posedge rdClk) begin
        if (rdRst) begin
            empty <= 1'b1;
        end else if (!almostEmpty) begin
            empty <= 1'b0;
        end else if (pop) begin
            empty <= 1'b1;
        end else begin
            empty <= rawEmpty;                  // plain level
        end
    end

endmodule

// File: hdl/wrPtrCtrl.sv
/*
 * write pointer and almost-full
 * counts stored words and compares the write pointer against the
 * synchronized read pointer to flag low free space
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module wrPtrCtrl #(
    parameter int Offset = `DEF_OFFSET      // free entries that raise almostFull
) (
    input  logic              wr_clk,
    input  logic              wr_rst_q,
    input  logic              memWrite,
    input  bramFifoPkg::ptr_t rdPtrSync,    // read pointer, already in this domain
    output bramFifoPkg::ptr_t wrPtr,
    output logic              almostFull
);

    logic              wrapDiff;            // writer is one lap ahead
    bramFifoPkg::ptr_t usedCnt;
    bramFifoPkg::ptr_t freeCnt;

    // occupancy, adds a full depth when the wrap bits differ
    assign wrapDiff = wrPtr[`ADDR_BITS] ^ rdPtrSync[`ADDR_BITS];
    assign usedCnt  = {wrapDiff, wrPtr[`ADDR_BITS-1:0]}
                    - {1'b0, rdPtrSync[`ADDR_BITS-1:0]};
    assign freeCnt  = bramFifoPkg::ptr_t'(`FIFO_DEPTH) - usedCnt;

    // one step per stored word
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            wrPtr <= '0;
        end else if (memWrite) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    // read pointer lags, so free space is never overstated
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            almostFull <= 1'b1;                          // hold off writers
        end else begin
            almostFull <= (int'(freeCnt) <= Offset);
        end
    end

endmodule

// File: hdl/writeStage.sv
/*
 * write side input pipeline
 * accepts a word on wrEn while full is low, carries it through two
 * register stages to the lanes and delays almost-full by two cycles
 * so words still in flight have room
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module writeStage #(
    parameter int Width = 128                           // 1 to 360
) (
    input  logic                                    wr_clk,
    input  logic                                    wr_rst_q,
    input  logic [Width-1:0]                        din,
    input  logic                                    wrEn,
    input  logic                                    almostFull,
    output logic                                    full,
    output bramFifoPkg::laneWord_t [`MAX_LANES-1:0] laneDin,
    output logic                                    memWrite
);

    localparam int PadWidth = `MAX_LANES * `LANE_WIDTH;

    logic [Width-1:0] dinQ;         // stage one data
    logic [Width-1:0] midDin;       // stage two data, goes to the lanes
    logic             validQ;       // stage one valid
    logic             midFull;      // almost-full, one cycle old

    // data stages just follow the valid bits
    always_ff @(posedge wr_clk) begin
        dinQ   <= din;
        midDin <= dinQ;
    end

    // valid pipe, accept only while full is low
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            validQ   <= 1'b0;
            memWrite <= 1'b0;
        end else begin
            validQ   <= wrEn & ~full;
            memWrite <= validQ;     // stored two cycles after accept
        end
    end

    // full is almost-full seen two cycles late
    always_ff @(posedge wr_clk) begin
        if (wr_rst_q) begin
            midFull <= 1'b1;
            full    <= 1'b1;
        end else begin
            midFull <= almostFull;
            full    <= midFull;
        end
    end

    assign laneDin = PadWidth'(midDin);  // upper lanes zero padded

endmodule

// File: list.f
+incdir+hdl
hdl/bramFifoPkg.sv
hdl/writeStage.sv
hdl/grayPtrSync.sv
hdl/wrPtrCtrl.sv
hdl/rdPtrCtrl.sv
hdl/fifoLane.sv
hdl/asyncFifoBram.sv
tests/asyncFifoBram_props.sv
tests/asyncFifoBram_tb.sv

// File: tests/asyncFifoBram_props.sv
/*
 * flag checks for the dual-clock BRAM FIFO
 * bound into the top level, watches full, empty and the write strobe
 */
`timescale 1ns/100ps

module asyncFifoBram_props (
    input logic wr_clk,
    input logic wr_rst_q,
    input logic rdClk,
    input logic rdRst,
    input logic full,
    input logic empty,
    input logic memWrite,
    input logic almostFull
);

    int violations = 0;     // failures seen, summed up at the end of the run

    // falling edges, the first reset edge has already loaded the flags
    fullInReset: assert property (@(negedge wr_clk) wr_rst_q |-> full)
        else begin
            $error("full is low while the write reset is high");
            violations++;
        end

    emptyInReset: assert property (@(negedge rdClk) rdRst |-> empty)
        else begin
            $error("empty is low while the read reset is high");
            violations++;
        end

    noWriteInReset: assert property (@(negedge wr_clk) wr_rst_q |-> !memWrite)
        else begin
            $error("memWrite pulsed during the write reset");
            violations++;
        end

    // full is almostFull two edges late, so it may only fall after a low one
    fullFallsLate: assert property (@(posedge wr_clk) disable iff (wr_rst_q)
        $fell(full) |-> !$past(almostFull, 2))
        else begin
            $error("full fell although almostFull was high two cycles before");
            violations++;
        end

endmodule

bind asyncFifoBram asyncFifoBram_props uProps (
    .wr_clk     (wr_clk),
    .wr_rst_q   (wr_rst_q),
    .rdClk      (rdClk),
    .rdRst      (rdRst),
    .full       (full),
    .empty      (empty),
    .memWrite   (memWrite),
    .almostFull (almostFull)
);

// File: tests/asyncFifoBram_tb.sv
/*
 * testbench for the 130 bit dual-clock BRAM FIFO over two lanes
 * LFSR driven traffic, a queue as reference model and a read side
 * process that compares every popped word
 */
`timescale 1ns/100ps
`include "bramFifo_defines.svh"

module asyncFifoBram_tb;

    localparam int Width  = 130;           // second lane only partly used
    localparam int Offset = `DEF_OFFSET;

    logic             wr_clk;
    logic             wr_rst_q;
    logic             rdClk;
    logic             rdRst;
    logic [Width-1:0] din;
    logic             wrEn;
    logic             full;
    logic [Width-1:0] dout;
    logic             rdEn;
    logic             empty;

    logic [Width-1:0] refQ[$];             // accepted words with the oldest at the front
    int               acceptCnt = 0;
    int               popCnt    = 0;
    logic [31:0]      wrLfsr;              // one generator per clock domain
    logic [31:0]      rdLfsr;
    bit               writesDone;
    int               burstCnt;

    asyncFifoBram #(.Width(Width), .Offset(Offset)) dut (
        .wr_clk(wr_clk), .wr_rst_q(wr_rst_q), .rdClk(rdClk), .rdRst(rdRst),
        .din(din), .wrEn(wrEn), .full(full),
        .dout(dout), .rdEn(rdEn), .empty(empty)
    );

    initial begin
        wr_clk = 1'b0;
        forever #4 wr_clk = ~wr_clk;       // 8 ns
    end

    initial begin
        rdClk = 1'b0;
        forever #5.5 rdClk = ~rdClk;       // 11 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic lfsrBit(inout logic [31:0] s);
        logic outBit;
        outBit = s[0];
        s      = s >> 1;
        if (outBit) s = s ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        return outBit;
    endfunction

    function automatic logic [Width-1:0] takeBits(inout logic [31:0] s, input int n);
        logic [Width-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v[i] = lfsrBit(s);
        return v;
    endfunction

    // the oldest accepted word is always the next one out
    function automatic logic [Width-1:0] expectedHead();
        return refQ[0];
    endfunction

    task automatic flagMismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic abortWith(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // one write cycle ending 1 ns after the rising edge
    task automatic wrTick();
        @(posedge wr_clk);
        #1;
    endtask

    task automatic rdTick();
        @(posedge rdClk);
        #1;
    endtask

    task automatic waitFullLow(input int limit);
        int cycles;
        cycles = 0;
        while (full) begin
            if (cycles >= limit) abortWith("full stayed high and the write side never opened");
            wrTick();
            cycles++;
        end
    endtask

    // random wrEn on 3 of 4 cycles until nWords more are accepted
    task automatic writeRandom(input int nWords, input int limit);
        int target;
        int cycles;
        target = acceptCnt + nWords;
        cycles = 0;
        while (acceptCnt < target) begin
            if (cycles >= limit) abortWith("random writes stalled as the FIFO took no words");
            din  = takeBits(wrLfsr, Width);
            wrEn = (takeBits(wrLfsr, 2) != 0);
            wrTick();                       // accept recorded at the negedge before
            cycles++;
        end
        wrEn = 1'b0;
    endtask

    task automatic readRandom(input int limit);
        int cycles;
        cycles = 0;
        rdTick();
        while (!writesDone) begin
            if (cycles >= limit) abortWith("the read side waited too long for the writes to end");
            rdEn = (takeBits(rdLfsr, 2) != 0);
            rdTick();
            cycles++;
        end
        rdEn = 1'b0;
    endtask

    // rdEn stays high afterwards
    task automatic drainAll(input int limit);
        int cycles;
        cycles = 0;
        rdTick();
        rdEn = 1'b1;
        while (refQ.size() != 0) begin
            if (cycles >= limit) abortWith("words were written but never came out of the FIFO");
            rdTick();
            cycles++;
        end
        assert (empty) else abortWith("empty did not rise after the last word was read");
    endtask

    // nonstop writes with reads stopped give the number of words taken
    task automatic fillUntilFull(output int accepted);
        int startCnt;
        int cycles;
        startCnt = acceptCnt;
        cycles   = 0;
        wrEn     = 1'b1;
        din      = takeBits(wrLfsr, Width);
        wrTick();
        while (!full) begin
            if (cycles >= 2 * `FIFO_DEPTH) abortWith("full never rose with reads stopped");
            din = takeBits(wrLfsr, Width);
            wrTick();
            cycles++;
        end
        repeat (24) begin                   // keep pushing against full
            din = takeBits(wrLfsr, Width);
            wrTick();
            assert (full) else abortWith("full dropped although nothing was read");
        end
        wrEn     = 1'b0;
        accepted = acceptCnt - startCnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference queue and comparison
    ////////////////////////////////////////////////////////////////////////////

    // inputs and full are steady at the falling edge
    always @(negedge wr_clk) begin
        if (!wr_rst_q && wrEn && !full) begin
            refQ.push_back(din);
            acceptCnt++;
        end
    end

    always @(negedge rdClk) begin : compareProc
        logic [Width-1:0] expWord;
        if (!rdRst && rdEn && !empty) begin
            assert (refQ.size() != 0) else abortWith("the FIFO offered a word that was never written");
            expWord = expectedHead();
            assert (dout[`LANE_WIDTH-1:0] === expWord[`LANE_WIDTH-1:0])
                else flagMismatch($sformatf("pop %0d lane 0 got %h, expected %h", popCnt,
                                            dout[`LANE_WIDTH-1:0], expWord[`LANE_WIDTH-1:0]));
            assert (dout[Width-1:`LANE_WIDTH] === expWord[Width-1:`LANE_WIDTH])
                else flagMismatch($sformatf("pop %0d lane 1 got %h, expected %h", popCnt,
                                            dout[Width-1:`LANE_WIDTH], expWord[Width-1:`LANE_WIDTH]));
            void'(refQ.pop_front());
            popCnt++;
        end
    end

    // a failing flag assertion in the bound checker ends the run right away
    always @(dut.uProps.violations) begin
        assert (dut.uProps.violations == 0)
            else abortWith("a bound assertion on full, empty or memWrite failed");
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wr_rst_q   = 1'b1;
        rdRst      = 1'b1;
        din        = '0;
        wrEn       = 1'b0;
        rdEn       = 1'b0;
        wrLfsr     = 32'h9b83;
        rdLfsr     = 32'h9b83;
        writesDone = 1'b0;

        repeat (16) @(posedge wr_clk);
        #1;
        assert (full && empty) else abortWith("full or empty was low during reset");
        wr_rst_q = 1'b0;
        rdRst    = 1'b0;

        // full opens after reset and empty holds with nothing written
        waitFullLow(32);
        repeat (40) begin
            rdTick();
            assert (empty) else abortWith("empty fell before anything was written");
        end

        // random traffic both ways
        wrTick();
        fork
            begin
                writeRandom(2000, 20000);
                writesDone = 1'b1;
            end
            readRandom(40000);
        join
        drainAll(4000);
        rdEn = 1'b0;

        // pointers settle before the back-pressure fill
        wrTick();
        waitFullLow(64);
        repeat (10) wrTick();
        fillUntilFull(burstCnt);
        assert (burstCnt >= `FIFO_DEPTH - Offset - 2 && burstCnt <= `FIFO_DEPTH)
            else flagMismatch($sformatf("%0d words fit before full, expected %0d to %0d",
                                        burstCnt, `FIFO_DEPTH - Offset - 2, `FIFO_DEPTH));
        drainAll(4 * `FIFO_DEPTH);

        // rdEn held high on an empty FIFO
        repeat (40) begin
            rdTick();
            assert (empty) else abortWith("empty fell with no new data written");
        end
        wrTick();
        writeRandom(6, 200);
        drainAll(400);
        rdEn = 1'b0;

        // final drain results
        repeat (8) rdTick();
        assert (popCnt == acceptCnt)
            else flagMismatch($sformatf("%0d words popped, %0d accepted", popCnt, acceptCnt));
        assert (empty) else abortWith("empty is low after all traffic ended");

        if (dut.uProps.violations != 0) begin
            $display("flag assertions failed %0d times", dut.uProps.violations);
            $display("Some tests failed");
            $fatal(1);
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule
